//--- lsq_mem_system.f
+incdir+hw
hw/lsq_pkg.sv
hw/lsq_forward_match.sv
hw/lsq_entry_queue.sv
hw/dmem_delay_model.sv
hw/lsq_mem_system.sv
verif/lsq_mem_system_tb.sv

//--- Makefile
# Verilator build and run for the load/store queue

VERILATOR ?= verilator
TOP       ?= lsq_mem_system_tb
FILELIST  ?= lsq_mem_system.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/lsq_mem_system_tb.sv
// load/store queue testbench
`timescale 1ns/100ps
`include "lsq_params.svh"

module lsq_mem_system_tb import lsq_pkg::*; ();

  logic     clk;
  logic     rst;
  logic     i_ld;
  logic     i_st;
  word_t    i_addr;
  word_t    i_wdata;
  reg_idx_t i_rd;
  logic     o_full;
  logic     o_empty;
  logic     o_ret_valid;
  logic     o_ret_is_st;
  reg_idx_t o_ret_rd;
  word_t    o_ret_data;

  // stimulus table with one row per request
  logic     tbl_st   [64];  // 1 = store
  word_t    tbl_addr [64];
  word_t    tbl_data [64];
  reg_idx_t tbl_rd   [64];
  int       tbl_idle [64];  // idle cycles after the row
  int       n_rows;

  // reference model
  word_t    model_mem [`DMEM_WORDS];
  logic     exp_st [$];    // expected retirements in program order
  reg_idx_t exp_rd [$];
  word_t    exp_data [$];

  int       err_count;
  int       check_count;
  int       retire_count;
  int       test_num;
  int       tests_failed;
  int       err_at_start;
  bit       timed_out;
  int       seed;

  lsq_mem_system i_dut (
    .clk         (clk),
    .rst         (rst),
    .i_ld        (i_ld),
    .i_st        (i_st),
    .i_addr      (i_addr),
    .i_wdata     (i_wdata),
    .i_rd        (i_rd),
    .o_full      (o_full),
    .o_empty     (o_empty),
    .o_ret_valid (o_ret_valid),
    .o_ret_is_st (o_ret_is_st),
    .o_ret_rd    (o_ret_rd),
    .o_ret_data  (o_ret_data)
  );

  always #10 clk = ~clk;  // 20 ns period

  task automatic add_row(input logic st, input word_t addr, input word_t data,
                         input reg_idx_t rd, input int idle);
    tbl_st[n_rows]   = st;
    tbl_addr[n_rows] = addr;
    tbl_data[n_rows] = data;
    tbl_rd[n_rows]   = rd;
    tbl_idle[n_rows] = idle;
    n_rows++;
  endtask

  // strobe each row on a falling edge and update the model in program order
  task automatic run_rows();
    int n;

    for (int i = 0; i < n_rows && !timed_out; i++) begin
      @(negedge clk);
      n = 0;
      while (o_full && n < 100) begin  // hold off while the queue is full
        i_ld = 1'b0;
        i_st = 1'b0;
        @(negedge clk);
        n++;
      end
      if (o_full) begin
        $display("timeout: queue stayed full, row %0d never issued", i);
        timed_out = 1'b1;
      end
      i_ld    = !tbl_st[i];
      i_st    = tbl_st[i];
      i_addr  = tbl_addr[i];
      i_wdata = tbl_data[i];
      i_rd    = tbl_rd[i];
      exp_st.push_back(tbl_st[i]);
      exp_rd.push_back(tbl_rd[i]);
      if (tbl_st[i]) begin
        model_mem[tbl_addr[i][`DMEM_IDX_W+1:2]] = tbl_data[i];
        exp_data.push_back(tbl_data[i]);  // not compared for stores
      end else begin
        exp_data.push_back(model_mem[tbl_addr[i][`DMEM_IDX_W+1:2]]);
      end
      if (tbl_idle[i] > 0) begin
        @(negedge clk);
        i_ld = 1'b0;
        i_st = 1'b0;
        repeat (tbl_idle[i] - 1) @(negedge clk);
      end
    end
    @(negedge clk);
    i_ld = 1'b0;
    i_st = 1'b0;
  endtask

  // wait for every expected retirement and an empty queue
  task automatic drain();
    int n;

    n = 0;
    while ((exp_st.size() != 0 || !o_empty) && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (exp_st.size() != 0 || !o_empty) begin
      $display("timeout: %0d retirements missing or queue never emptied", exp_st.size());
      timed_out = 1'b1;
    end
  endtask

  task automatic start_test();
    test_num++;
    n_rows       = 0;
    err_at_start = err_count;
  endtask

  task automatic finish_test(input string name);
    if (err_count != err_at_start || timed_out) begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", test_num, name, err_count - err_at_start);
    end else begin
      $display("test %0d %s: ok", test_num, name);
    end
  endtask

  // retirement monitor samples on the falling edge
  always @(negedge clk) begin : ret_monitor
    logic     e_st;
    reg_idx_t e_rd;
    word_t    e_data;

    if (!rst && o_ret_valid) begin
      retire_count++;
      if (exp_st.size() == 0) begin
        $display("retirement seen with no request outstanding");
        err_count++;
      end else begin
        e_st   = exp_st.pop_front();
        e_rd   = exp_rd.pop_front();
        e_data = exp_data.pop_front();
        check_count++;
        if (o_ret_is_st !== e_st) begin
          $display("error o_ret_is_st got %h expected %h", o_ret_is_st, e_st);
          err_count++;
        end
        if (o_ret_rd !== e_rd) begin
          $display("error o_ret_rd got %h expected %h", o_ret_rd, e_rd);
          err_count++;
        end
        if (!e_st && o_ret_data !== e_data) begin  // load value only
          $display("error o_ret_data got %h expected %h", o_ret_data, e_data);
          err_count++;
        end
      end
    end
  end

  initial begin
    logic [31:0] r;
    int          rc0;

    clk  = 1'b0;
    rst  = 1'b1;
    i_ld = 1'b0;
    i_st = 1'b0;
    i_addr  = '0;
    i_wdata = '0;
    i_rd    = '0;
    seed = 74762;
    err_count = 0;
    check_count = 0;
    retire_count = 0;
    test_num = 0;
    tests_failed = 0;
    timed_out = 1'b0;
    for (int k = 0; k < `DMEM_WORDS; k++) begin
      model_mem[k] = word_t'(k);  // matches memory reset
    end

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // reset state and untouched words
    start_test();
    check_count += 2;
    if (o_empty !== 1'b1) begin
      $display("error o_empty got %h expected %h", o_empty, 1'b1);
      err_count++;
    end
    if (o_full !== 1'b0) begin
      $display("error o_full got %h expected %h", o_full, 1'b0);
      err_count++;
    end
    rc0 = retire_count;
    repeat (20) @(negedge clk);
    if (retire_count != rc0) begin
      $display("retirement appeared with nothing issued after reset");
      err_count++;
    end
    add_row(1'b0, 32'h40, 32'h0, 4'd1, 0);
    add_row(1'b0, 32'h84, 32'h0, 4'd2, 3);
    run_rows();
    drain();
    finish_test("reset and untouched loads");

    // store then idle then load of the same word
    if (!timed_out) begin
      start_test();
      add_row(1'b1, 32'h40, 32'hdeadbeef, 4'd1, 8);
      add_row(1'b0, 32'h40, 32'h0, 4'd2, 0);
      run_rows();
      drain();
      finish_test("store then load");
    end

    // forwarding from the youngest store
    if (!timed_out) begin
      start_test();
      add_row(1'b1, 32'h80, 32'h00001234, 4'd3, 0);
      add_row(1'b0, 32'h80, 32'h0, 4'd4, 0);
      add_row(1'b1, 32'hc0, 32'h0000aaaa, 4'd5, 0);
      add_row(1'b1, 32'hc0, 32'h0000bbbb, 4'd6, 0);
      add_row(1'b0, 32'hc0, 32'h0, 4'd7, 4);
      run_rows();
      drain();
      finish_test("store to load forwarding");
    end

    // random back to back burst over four words
    if (!timed_out) begin
      start_test();
      for (int i = 0; i < 24; i++) begin
        r = $random(seed);
        add_row(r[2], 32'h100 + {28'd0, r[1:0], 2'b00}, $random(seed), r[7:4], 0);
      end
      run_rows();
      drain();
      finish_test("random burst");
    end

    // sixteen back to back loads
    if (!timed_out) begin
      start_test();
      rc0 = retire_count;
      for (int i = 0; i < 16; i++) begin
        add_row(1'b0, 32'h200 + (word_t'(i) << 2), 32'h0, reg_idx_t'(i), 0);
      end
      run_rows();
      check_count++;
      if (o_empty !== 1'b0) begin  // last load taken one edge ago
        $display("error o_empty got %h expected %h", o_empty, 1'b0);
        err_count++;
      end
      drain();
      check_count++;
      if (retire_count - rc0 != 16) begin
        $display("error retire count got %h expected %h", retire_count - rc0, 16);
        err_count++;
      end
      finish_test("sixteen loads");
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_num, tests_failed, check_count, err_count);
    if (timed_out || err_count != 0) begin
      $display("CHECKS FAILED");
    end else begin
      $display("ALL CHECKS PASSED");
    end
    $finish;
  end

endmodule

//--- hw/lsq_mem_system.sv
// queue and memory top level
`timescale 1ns/100ps
`include "lsq_params.svh"

module lsq_mem_system import lsq_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     i_ld,
  input  logic     i_st,
  input  word_t    i_addr,
  input  word_t    i_wdata,
  input  reg_idx_t i_rd,
  output logic     o_full,
  output logic     o_empty,
  output logic     o_ret_valid,
  output logic     o_ret_is_st,
  output reg_idx_t o_ret_rd,
  output word_t    o_ret_data
);

  // request path, queue to memory
  logic     mem_valid;
  logic     mem_rw;
  word_t    mem_addr;
  word_t    mem_wdata;
  lsq_idx_t mem_id;
  // response path, memory to queue
  logic     mem_ready;
  lsq_idx_t mem_rsp_id;
  word_t    mem_rdata;

  lsq_entry_queue u_queue (
    .clk         (clk),
    .rst         (rst),
    .i_ld        (i_ld),
    .i_st        (i_st),
    .i_addr      (i_addr),
    .i_wdata     (i_wdata),
    .i_rd        (i_rd),
    .o_full      (o_full),
    .o_empty     (o_empty),
    .o_mem_valid (mem_valid),
    .o_mem_rw    (mem_rw),
    .o_mem_addr  (mem_addr),
    .o_mem_wdata (mem_wdata),
    .o_mem_id    (mem_id),
    .i_mem_ready (mem_ready),
    .i_mem_id    (mem_rsp_id),
    .i_mem_rdata (mem_rdata),
    .o_ret_valid (o_ret_valid),
    .o_ret_is_st (o_ret_is_st),
    .o_ret_rd    (o_ret_rd),
    .o_ret_data  (o_ret_data)
  );

  dmem_delay_model u_dmem (
    .clk     (clk),
    .rst     (rst),
    .i_valid (mem_valid),
    .i_rw    (mem_rw),
    .i_addr  (mem_addr),
    .i_wdata (mem_wdata),
    .i_id    (mem_id),
    .o_ready (mem_ready),
    .o_id    (mem_rsp_id),
    .o_rdata (mem_rdata)
  );

endmodule

//--- hw/dmem_delay_model.sv
// fixed latency data memory
`timescale 1ns/100ps
`include "lsq_params.svh"

module dmem_delay_model import lsq_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     i_valid,
  input  logic     i_rw,     // 1 = store
  input  word_t    i_addr,
  input  word_t    i_wdata,
  input  lsq_idx_t i_id,
  output logic     o_ready,
  output lsq_idx_t o_id,
  output word_t    o_rdata
);

  word_t                  mem [`DMEM_WORDS];
  logic [`DMEM_IDX_W-1:0] widx;   // word index, byte offset dropped

  // two delay stages ahead of the output registers
  logic                   s0_vld;
  logic                   s1_vld;
  lsq_idx_t               s0_id;
  lsq_idx_t               s1_id;
  word_t                  s0_data;
  word_t                  s1_data;

  assign widx = i_addr[`DMEM_IDX_W+1:2];

  // storage, word k comes out of reset holding k
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < `DMEM_WORDS; k++) begin
        mem[k] <= word_t'(k);
      end
    end else if (i_valid && i_rw) begin
      mem[widx] <= i_wdata;
    end
  end

  // response valid pipe
  always_ff @(posedge clk) begin
    if (rst) begin
      s0_vld  <= 1'b0;
      s1_vld  <= 1'b0;
      o_ready <= 1'b0;
    end else begin
      s0_vld  <= i_valid;  // access done at sample edge
      s1_vld  <= s0_vld;
      o_ready <= s1_vld;   // visible after sample edge + 2
    end
  end

  // id and data follow the valid bit
  always_ff @(posedge clk) begin
    s0_id   <= i_id;
    s0_data <= i_rw ? '0 : mem[widx];  // stores answer with zero
    s1_id   <= s0_id;
    s1_data <= s0_data;
    o_id    <= s1_id;
    o_rdata <= s1_data;
  end

endmodule

//--- hw/lsq_entry_queue.sv
// load/store entry queue
`timescale 1ns/100ps
`include "lsq_params.svh"

module lsq_entry_queue import lsq_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  // core requests
  input  logic     i_ld,
  input  logic     i_st,
  input  word_t    i_addr,
  input  word_t    i_wdata,
  input  reg_idx_t i_rd,
  output logic     o_full,
  output logic     o_empty,
  // to data memory
  output logic     o_mem_valid,
  output logic     o_mem_rw,      // 1 = store
  output word_t    o_mem_addr,
  output word_t    o_mem_wdata,
  output lsq_idx_t o_mem_id,
  // from data memory
  input  logic     i_mem_ready,
  input  lsq_idx_t i_mem_id,
  input  word_t    i_mem_rdata,
  // retirement to core
  output logic     o_ret_valid,
  output logic     o_ret_is_st,
  output reg_idx_t o_ret_rd,
  output word_t    o_ret_data
);

  // per-entry state
  logic [`LSQ_DEPTH-1:0] valid_q;  // slot occupied
  logic [`LSQ_DEPTH-1:0] done_q;   // result in hand and ready to retire
  logic [`LSQ_DEPTH-1:0] store_q;
  lsq_addr_vec_t         addr_q;
  word_t                 data_q [`LSQ_DEPTH];  // store data or load result
  reg_idx_t              rd_q [`LSQ_DEPTH];

  // pointers
  lsq_idx_t              head_q;   // oldest entry
  lsq_idx_t              tail_q;   // next free slot
  logic [`LSQ_CNT_W-1:0] count_q;

  logic                  accept;   // request taken this cycle
  logic                  retire;   // head leaves this cycle
  logic                  fwd_hit;
  logic                  fwd_load; // load served from the queue
  lsq_idx_t              fwd_idx;

  assign accept   = (i_ld || i_st) && !o_full;   // strobe while full is dropped
  assign retire   = valid_q[head_q] && done_q[head_q];
  assign fwd_load = accept && !i_st && fwd_hit;  // both strobes = store

  assign o_full  = (count_q == `LSQ_CNT_W'(`LSQ_DEPTH));
  assign o_empty = (count_q == '0);

  lsq_forward_match u_fwd (
    .i_addr      (i_addr),
    .i_valid_vec (valid_q),
    .i_store_vec (store_q),
    .i_addr_vec  (addr_q),
    .i_tail      (tail_q),
    .o_hit       (fwd_hit),
    .o_idx       (fwd_idx)
  );

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q     <= '0;
      done_q      <= '0;
      head_q      <= '0;
      tail_q      <= '0;
      count_q     <= '0;
      o_mem_valid <= 1'b0;
      o_ret_valid <= 1'b0;
    end else begin
      if (accept) begin
        valid_q[tail_q] <= 1'b1;
        done_q[tail_q]  <= fwd_load;  // forwarded load is born complete
        tail_q          <= tail_q + 1'b1;
      end
      if (i_mem_ready) begin
        done_q[i_mem_id] <= 1'b1;     // id is always an in-flight slot
      end
      if (retire) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= head_q + 1'b1;
      end

      // simultaneous enqueue and retire cancel out
      if (accept && !retire) begin
        count_q <= count_q + 1'b1;
      end else if (retire && !accept) begin
        count_q <= count_q - 1'b1;
      end

      o_mem_valid <= accept && !fwd_load;  // one issue per accepted request
      o_ret_valid <= retire;
    end
  end

  // entry payload and memory request
  always_ff @(posedge clk) begin
    if (accept) begin
      store_q[tail_q] <= i_st;
      addr_q[tail_q]  <= i_addr;
      rd_q[tail_q]    <= i_rd;
      data_q[tail_q]  <= fwd_load ? data_q[fwd_idx] : i_wdata;
      // registered issue sampled by memory next edge
      o_mem_rw        <= i_st;
      o_mem_addr      <= i_addr;
      o_mem_wdata     <= i_wdata;
      o_mem_id        <= tail_q;
    end
    if (i_mem_ready && !store_q[i_mem_id]) begin
      data_q[i_mem_id] <= i_mem_rdata;  // store keeps its own data
    end
    if (retire) begin
      o_ret_is_st <= store_q[head_q];
      o_ret_rd    <= rd_q[head_q];
      o_ret_data  <= data_q[head_q];
    end
  end

endmodule

//--- hw/lsq_forward_match.sv
// store to load forward search
`timescale 1ns/100ps
`include "lsq_params.svh"

module lsq_forward_match import lsq_pkg::*; (
  input  word_t                 i_addr,       // address of incoming load
  input  logic [`LSQ_DEPTH-1:0] i_valid_vec,  // occupied slots
  input  logic [`LSQ_DEPTH-1:0] i_store_vec,  // slot holds a store
  input  lsq_addr_vec_t         i_addr_vec,   // per-slot addresses
  input  lsq_idx_t              i_tail,       // next free slot
  output logic                  o_hit,
  output lsq_idx_t              o_idx         // youngest matching store
);

  logic [`LSQ_DEPTH-1:0] match;  // valid store at same address

  // compare against every slot in parallel
  always_comb begin
    for (int i = 0; i < `LSQ_DEPTH; i++) begin
      match[i] = i_valid_vec[i] && i_store_vec[i] && (i_addr_vec[i] == i_addr);
    end
  end

  // walk back from the tail, oldest first, so the nearest match wins
  // distance DEPTH wraps to the tail slot itself, the head when full
  always_comb begin
    lsq_idx_t cand;

    o_hit = 1'b0;
    o_idx = '0;
    for (int k = `LSQ_DEPTH; k >= 1; k--) begin
      cand = i_tail - lsq_idx_t'(k);  // k slots behind the tail
      if (match[cand]) begin
        o_hit = 1'b1;
        o_idx = cand;  // later (younger) hits overwrite
      end
    end
  end

endmodule

//--- hw/lsq_pkg.sv
// load/store queue types
`include "lsq_params.svh"

package lsq_pkg;

  // one address or data word
  typedef logic [`WORD_W-1:0] word_t;

  // queue slot number, doubles as memory request id
  typedef logic [`LSQ_IDX_W-1:0] lsq_idx_t;

  // destination register of a load
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;

  // every entry address side by side, slot 0 in the low word
  typedef logic [`LSQ_DEPTH-1:0][`WORD_W-1:0] lsq_addr_vec_t;

endpackage

//--- hw/lsq_params.svh
// load/store queue sizes
`ifndef LSQ_PARAMS_SVH
`define LSQ_PARAMS_SVH

// queue geometry
`define LSQ_DEPTH   16   // entries
`define LSQ_IDX_W   4    // entry index bits
`define LSQ_CNT_W   5    // occupancy count, 0..16

// datapath
`define WORD_W      32   // address and data width
`define REG_IDX_W   4    // write-back register number

// data memory
`define DMEM_WORDS  256  // word count
`define DMEM_IDX_W  8    // word index bits

`endif
